// File: gfx_fb_pkg.sv
package gfx_fb_pkg;

  // Frame geometry
  localparam int fb_width      = 16;
  localparam int fb_height     = 12;
  localparam int fb_pixels     = fb_width * fb_height;
  localparam int fb_pixel_bits = 12;

  // Coordinate and address widths
  localparam int fb_x_bits    = 4;
  localparam int fb_y_bits    = 4;
  localparam int fb_addr_bits = 8;

  typedef logic [fb_x_bits-1:0]     fb_x_t;
  typedef logic [fb_y_bits-1:0]     fb_y_t;
  typedef logic [fb_pixel_bits-1:0] fb_color_t;

  // Last coordinate of the raster walk
  localparam fb_x_t fb_max_x = fb_x_t'(fb_width - 1);
  localparam fb_y_t fb_max_y = fb_y_t'(fb_height - 1);

  // One pixel write on the internal stream
  typedef struct packed {
    fb_x_t     x;
    fb_y_t     y;
    fb_color_t color;
  } fb_pixel_t;

  // True when the coordinate lies inside the visible frame
  function automatic logic fb_in_frame(fb_x_t x, fb_y_t y);
    return (int'(x) < fb_width) && (int'(y) < fb_height);
  endfunction

endpackage

// File: gfx_cmd_pkg.sv
package gfx_cmd_pkg;

  typedef enum logic [1:0] {
    op_clear = 2'd0,
    op_plot  = 2'd1
  } gfx_op_e;

  // Command as presented with cmd_valid
  typedef struct packed {
    gfx_op_e               op;
    gfx_fb_pkg::fb_x_t     x;
    gfx_fb_pkg::fb_y_t     y;
    gfx_fb_pkg::fb_color_t color;
  } gfx_cmd_t;

  // Controller FSM states
  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_clear  = 2'd1,
    st_plot   = 2'd2,
    st_finish = 2'd3
  } gfx_state_e;

endpackage

// File: gfx_clear.sv
`timescale 1ns/1ps

module gfx_clear (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  gfx_fb_pkg::fb_color_t color,
  output gfx_fb_pkg::fb_pixel_t pix,
  output logic                  pvalid,
  input  logic                  pready,
  output logic                  last
);

  gfx_fb_pkg::fb_x_t     cur_x;
  gfx_fb_pkg::fb_y_t     cur_y;
  gfx_fb_pkg::fb_color_t color_q;
  logic                  xfer;
  logic                  at_end;

  assign xfer   = pvalid && pready;
  assign at_end = (cur_x == gfx_fb_pkg::fb_max_x) && (cur_y == gfx_fb_pkg::fb_max_y);

  // Final coordinate is flagged only while it is actually offered
  assign last = pvalid && at_end;

  assign pix = '{x: cur_x, y: cur_y, color: color_q};

  // Clear color held for the whole frame
  always_ff @(posedge clk) begin
    if (start) begin
      color_q <= color;
    end
  end

  // Raster counters, x first then y
  always_ff @(posedge clk) begin
    if (reset) begin
      cur_x <= '0;
      cur_y <= '0;
    end else if (start) begin
      cur_x <= '0;
      cur_y <= '0;
    end else if (xfer && !at_end) begin
      if (cur_x == gfx_fb_pkg::fb_max_x) begin
        cur_x <= '0;
        cur_y <= cur_y + 1'b1;
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  // Stream stays valid from start until the last pixel is taken
  always_ff @(posedge clk) begin
    if (reset) begin
      pvalid <= 1'b0;
    end else if (start) begin
      pvalid <= 1'b1;
    end else if (xfer && at_end) begin
      pvalid <= 1'b0;
    end
  end

endmodule

// File: gfx_cmd_ctrl.sv
`timescale 1ns/1ps

module gfx_cmd_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cmd_valid,
  input  gfx_cmd_pkg::gfx_cmd_t  cmd,
  output logic                   busy,
  output logic                   done,
  output logic                   clr_start,
  output gfx_fb_pkg::fb_color_t  clr_color,
  input  gfx_fb_pkg::fb_pixel_t  clr_pix,
  input  logic                   clr_pvalid,
  input  logic                   clr_last,
  output logic                   clr_pready,
  output gfx_fb_pkg::fb_pixel_t  wr_pix,
  output logic                   wr_pvalid,
  input  logic                   wr_pready
);

  gfx_cmd_pkg::gfx_state_e state;
  gfx_cmd_pkg::gfx_state_e state_next;
  gfx_cmd_pkg::gfx_cmd_t   cmd_q;
  gfx_fb_pkg::fb_pixel_t   plot_pix;
  logic                    accept;
  logic                    wr_xfer;
  logic                    in_clear;

  // Strobes arriving while busy are simply dropped
  assign accept   = cmd_valid && (state == gfx_cmd_pkg::st_idle);
  assign wr_xfer  = wr_pvalid && wr_pready;
  assign in_clear = (state == gfx_cmd_pkg::st_clear);

  always_comb begin
    state_next = state;
    unique case (state)
      gfx_cmd_pkg::st_idle: begin
        if (accept) begin
          if (cmd.op == gfx_cmd_pkg::op_clear) begin
            state_next = gfx_cmd_pkg::st_clear;
          end else if (cmd.op == gfx_cmd_pkg::op_plot &&
                       gfx_fb_pkg::fb_in_frame(cmd.x, cmd.y)) begin
            state_next = gfx_cmd_pkg::st_plot;
          end else begin
            // Off-frame plot or unknown op completes without a write
            state_next = gfx_cmd_pkg::st_finish;
          end
        end
      end
      gfx_cmd_pkg::st_clear: begin
        if (wr_xfer && clr_last) begin
          state_next = gfx_cmd_pkg::st_finish;
        end
      end
      gfx_cmd_pkg::st_plot: begin
        if (wr_xfer) begin
          state_next = gfx_cmd_pkg::st_finish;
        end
      end
      gfx_cmd_pkg::st_finish: begin
        state_next = gfx_cmd_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= gfx_cmd_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  // Registered so the first clear pixel lands two cycles after acceptance
  always_ff @(posedge clk) begin
    if (reset) begin
      clr_start <= 1'b0;
    end else begin
      clr_start <= accept && (cmd.op == gfx_cmd_pkg::op_clear);
    end
  end

  assign clr_color = cmd_q.color;
  assign plot_pix  = '{x: cmd_q.x, y: cmd_q.y, color: cmd_q.color};

  // Stream mux toward the writer
  assign wr_pix     = in_clear ? clr_pix : plot_pix;
  assign wr_pvalid  = (state == gfx_cmd_pkg::st_plot) || (in_clear && clr_pvalid);
  assign clr_pready = in_clear && wr_pready;

  assign busy = (state != gfx_cmd_pkg::st_idle);
  assign done = (state == gfx_cmd_pkg::st_finish);

endmodule

// File: gfx_fb_writer.sv
`timescale 1ns/1ps

module gfx_fb_writer (
  input  logic                  clk,
  input  logic                  reset,
  input  gfx_fb_pkg::fb_pixel_t wr_pix,
  input  logic                  wr_pvalid,
  output logic                  wr_pready,
  input  logic                  rd_en,
  input  gfx_fb_pkg::fb_x_t     rd_x,
  input  gfx_fb_pkg::fb_y_t     rd_y,
  output logic                  rd_valid,
  output gfx_fb_pkg::fb_color_t rd_data
);

  gfx_fb_pkg::fb_color_t mem [gfx_fb_pkg::fb_pixels];

  logic [gfx_fb_pkg::fb_addr_bits-1:0] wr_addr;
  logic [gfx_fb_pkg::fb_addr_bits-1:0] rd_addr;
  logic                                wr_xfer;
  logic                                wr_ok;
  logic                                rd_ok;

  // Row-major layout, y * width + x
  function automatic logic [gfx_fb_pkg::fb_addr_bits-1:0] fb_addr(
    gfx_fb_pkg::fb_x_t x,
    gfx_fb_pkg::fb_y_t y
  );
    return gfx_fb_pkg::fb_addr_bits'(int'(y) * gfx_fb_pkg::fb_width + int'(x));
  endfunction

  assign wr_addr = fb_addr(wr_pix.x, wr_pix.y);
  assign rd_addr = fb_addr(rd_x, rd_y);
  assign wr_ok   = gfx_fb_pkg::fb_in_frame(wr_pix.x, wr_pix.y);
  assign rd_ok   = gfx_fb_pkg::fb_in_frame(rd_x, rd_y);

  // Reads own the single port, so the stream stalls in read cycles
  assign wr_pready = !rd_en;
  assign wr_xfer   = wr_pvalid && wr_pready;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (rd_ok) begin
        rd_data <= mem[rd_addr];
      end else begin
        rd_data <= '0;
      end
    end else if (wr_xfer && wr_ok) begin
      mem[wr_addr] <= wr_pix.color;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

endmodule

// File: gfx_top.sv
`timescale 1ns/1ps

module gfx_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_valid,
  input  gfx_cmd_pkg::gfx_cmd_t cmd,
  output logic                  busy,
  output logic                  done,
  input  logic                  rd_en,
  input  gfx_fb_pkg::fb_x_t     rd_x,
  input  gfx_fb_pkg::fb_y_t     rd_y,
  output logic                  rd_valid,
  output gfx_fb_pkg::fb_color_t rd_data
);

  // Clear generator stream
  logic                  clr_start;
  gfx_fb_pkg::fb_color_t clr_color;
  gfx_fb_pkg::fb_pixel_t clr_pix;
  logic                  clr_pvalid;
  logic                  clr_pready;
  logic                  clr_last;

  // Muxed stream into the framebuffer
  gfx_fb_pkg::fb_pixel_t wr_pix;
  logic                  wr_pvalid;
  logic                  wr_pready;

  gfx_cmd_ctrl ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .busy       (busy),
    .done       (done),
    .clr_start  (clr_start),
    .clr_color  (clr_color),
    .clr_pix    (clr_pix),
    .clr_pvalid (clr_pvalid),
    .clr_last   (clr_last),
    .clr_pready (clr_pready),
    .wr_pix     (wr_pix),
    .wr_pvalid  (wr_pvalid),
    .wr_pready  (wr_pready)
  );

  gfx_clear clear0 (
    .clk    (clk),
    .reset  (reset),
    .start  (clr_start),
    .color  (clr_color),
    .pix    (clr_pix),
    .pvalid (clr_pvalid),
    .pready (clr_pready),
    .last   (clr_last)
  );

  gfx_fb_writer writer0 (
    .clk       (clk),
    .reset     (reset),
    .wr_pix    (wr_pix),
    .wr_pvalid (wr_pvalid),
    .wr_pready (wr_pready),
    .rd_en     (rd_en),
    .rd_x      (rd_x),
    .rd_y      (rd_y),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

endmodule

// File: tb_gfx_asserts.sv
`timescale 1ns/1ps

module tb_gfx_asserts (
  input logic                  clk,
  input logic                  reset,
  input logic                  busy,
  input logic                  done,
  input gfx_fb_pkg::fb_pixel_t wr_pix,
  input logic                  wr_pvalid,
  input logic                  wr_pready
);

  int fail_count = 0;

  // A stalled pixel is offered again unchanged
  stream_hold: assert property (@(posedge clk) disable iff (reset)
    wr_pvalid && !wr_pready |=> wr_pvalid && $stable(wr_pix))
  else begin
    fail_count++;
    $error("pixel stream dropped or changed a stalled pixel");
  end

  done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
  else begin
    fail_count++;
    $error("done stayed high for more than one cycle");
  end

  // Engine is free again right after completion
  idle_after_done: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
  else begin
    fail_count++;
    $error("busy still high in the cycle after done");
  end

endmodule

bind gfx_cmd_ctrl tb_gfx_asserts asserts0 (
  .clk       (clk),
  .reset     (reset),
  .busy      (busy),
  .done      (done),
  .wr_pix    (wr_pix),
  .wr_pvalid (wr_pvalid),
  .wr_pready (wr_pready)
);

// File: tb_gfx_checker.sv
`timescale 1ns/1ps

module tb_gfx_checker;

  gfx_fb_pkg::fb_color_t ref_frame [gfx_fb_pkg::fb_pixels];
  gfx_fb_pkg::fb_color_t old_frame [gfx_fb_pkg::fb_pixels];

  int                    err_count = 0;
  bit                    clear_active;
  bit                    rd_pend;
  gfx_fb_pkg::fb_x_t     rd_x_q;
  gfx_fb_pkg::fb_y_t     rd_y_q;
  gfx_fb_pkg::fb_color_t exp_new;
  gfx_fb_pkg::fb_color_t exp_old;

  function automatic bit on_frame(gfx_fb_pkg::fb_x_t x, gfx_fb_pkg::fb_y_t y);
    return (int'(x) < gfx_fb_pkg::fb_width) && (int'(y) < gfx_fb_pkg::fb_height);
  endfunction

  // Expected read data, optionally from the frame as it was before the running clear
  function automatic gfx_fb_pkg::fb_color_t expected_color(gfx_fb_pkg::fb_x_t x,
                                                           gfx_fb_pkg::fb_y_t y,
                                                           bit before_clear);
    int idx;
    idx = int'(y) * gfx_fb_pkg::fb_width + int'(x);
    if (!on_frame(x, y)) begin
      return '0;
    end
    return before_clear ? old_frame[idx] : ref_frame[idx];
  endfunction

  task automatic update_model(gfx_cmd_pkg::gfx_cmd_t c);
    if (c.op == gfx_cmd_pkg::op_clear) begin
      old_frame = ref_frame;
      foreach (ref_frame[i]) begin
        ref_frame[i] = c.color;
      end
      clear_active = 1'b1;
    end else if (c.op == gfx_cmd_pkg::op_plot && on_frame(c.x, c.y)) begin
      ref_frame[int'(c.y) * gfx_fb_pkg::fb_width + int'(c.x)] = c.color;
    end
  endtask

  always @(posedge tb_gfx.clk) begin
    if (tb_gfx.reset) begin
      rd_pend      = 1'b0;
      clear_active = 1'b0;
    end else begin
      // Data belongs to the read issued one cycle earlier
      if (tb_gfx.rd_valid && !rd_pend) begin
        err_count++;
        $display("rd_valid came without a read one cycle earlier");
      end else if (rd_pend && !tb_gfx.rd_valid) begin
        err_count++;
        $display("No rd_valid one cycle after the read of (%0d,%0d)", rd_x_q, rd_y_q);
      end else if (rd_pend && tb_gfx.rd_data !== exp_new && tb_gfx.rd_data !== exp_old) begin
        err_count++;
        if (exp_new == exp_old) begin
          $display("Error: %s: pixel (%0d,%0d) expected %03h actual %03h",
                   tb_gfx.test_name, rd_x_q, rd_y_q, exp_new, tb_gfx.rd_data);
        end else begin
          $display("Error: %s: pixel (%0d,%0d) expected %03h or %03h actual %03h",
                   tb_gfx.test_name, rd_x_q, rd_y_q, exp_old, exp_new, tb_gfx.rd_data);
        end
      end
      // Expectation is taken before this edge's command lands in the model
      rd_pend = tb_gfx.rd_en;
      if (tb_gfx.rd_en) begin
        rd_x_q  = tb_gfx.rd_x;
        rd_y_q  = tb_gfx.rd_y;
        exp_new = expected_color(tb_gfx.rd_x, tb_gfx.rd_y, 1'b0);
        exp_old = clear_active ? expected_color(tb_gfx.rd_x, tb_gfx.rd_y, 1'b1) : exp_new;
      end
      if (tb_gfx.done) begin
        clear_active = 1'b0;
      end
      if (tb_gfx.cmd_valid && !tb_gfx.busy) begin
        update_model(tb_gfx.cmd);
      end
    end
  end

endmodule

// File: tb_gfx.sv
`timescale 1ns/1ps

module tb_gfx;

  localparam int clk_period  = 8;
  localparam int n_tests     = 6;
  // One full clear plus reads and slack per test
  localparam int test_cycles = gfx_fb_pkg::fb_pixels + 400;
  localparam int cmd_timeout = test_cycles;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  cmd_valid;
  gfx_cmd_pkg::gfx_cmd_t cmd;
  logic                  busy;
  logic                  done;
  logic                  rd_en;
  gfx_fb_pkg::fb_x_t     rd_x;
  gfx_fb_pkg::fb_y_t     rd_y;
  logic                  rd_valid;
  gfx_fb_pkg::fb_color_t rd_data;

  string test_name;
  int    tb_errors = 0;
  int    done_count = 0;
  int    errs_at_start;
  int    tests_passed = 0;
  int    tests_failed = 0;

  always #(clk_period / 2) clk = ~clk;

  gfx_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .done      (done),
    .rd_en     (rd_en),
    .rd_x      (rd_x),
    .rd_y      (rd_y),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  tb_gfx_checker checker0 ();

  always @(posedge clk) begin
    if (!reset && done) begin
      done_count++;
    end
  end

  function automatic int total_errors();
    return tb_errors + checker0.err_count + dut0.ctrl0.asserts0.fail_count;
  endfunction

  // Cycles from the one after acceptance until done, with no reads
  function automatic int done_latency(gfx_cmd_pkg::gfx_op_e op, gfx_fb_pkg::fb_x_t x,
                                      gfx_fb_pkg::fb_y_t y);
    if (op == gfx_cmd_pkg::op_clear) begin
      return gfx_fb_pkg::fb_pixels + 1;
    end
    if (int'(x) < gfx_fb_pkg::fb_width && int'(y) < gfx_fb_pkg::fb_height) begin
      return 1;
    end
    return 0;
  endfunction

  task automatic begin_test(input string name);
    test_name     = name;
    errs_at_start = total_errors();
  endtask

  task automatic end_test();
    if (total_errors() == errs_at_start) begin
      tests_passed++;
      $display("Test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", test_name, total_errors() - errs_at_start);
    end
  endtask

  task automatic strobe_cmd(input gfx_cmd_pkg::gfx_op_e op, input gfx_fb_pkg::fb_x_t x,
                            input gfx_fb_pkg::fb_y_t y, input gfx_fb_pkg::fb_color_t color);
    cmd.op    = op;
    cmd.x     = x;
    cmd.y     = y;
    cmd.color = color;
    cmd_valid = 1'b1;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic check_done_once(input int start_done);
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    if (done_count - start_done != 1) begin
      tb_errors++;
      $display("Error: %s: done pulses expected 1 actual %0d",
               test_name, done_count - start_done);
    end
  endtask

  task automatic run_cmd(input gfx_cmd_pkg::gfx_op_e op, input gfx_fb_pkg::fb_x_t x,
                         input gfx_fb_pkg::fb_y_t y, input gfx_fb_pkg::fb_color_t color);
    int start_done;
    int waited;
    start_done = done_count;
    strobe_cmd(op, x, y, color);
    waited = 0;
    while (!done && waited < cmd_timeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!done) begin
      tb_errors++;
      $display("Command did not signal done within %0d cycles", cmd_timeout);
    end else if (waited != done_latency(op, x, y)) begin
      tb_errors++;
      $display("Error: %s: done latency expected %0d actual %0d",
               test_name, done_latency(op, x, y), waited);
    end
    check_done_once(start_done);
  endtask

  // Clear with random reads, and optionally a plot strobe while busy
  task automatic clear_with_traffic(input gfx_fb_pkg::fb_color_t color, input int read_pct,
                                    input bit inject);
    int cycles;
    int reads;
    int start_done;
    cycles     = 0;
    reads      = 0;
    start_done = done_count;
    strobe_cmd(gfx_cmd_pkg::op_clear, '0, '0, color);
    while (busy && cycles < cmd_timeout) begin
      rd_en = ($urandom % 100) < read_pct;
      rd_x  = gfx_fb_pkg::fb_x_t'($urandom);
      rd_y  = gfx_fb_pkg::fb_y_t'($urandom);
      if (rd_en) begin
        reads++;
      end
      cmd_valid = inject && (cycles == 40);
      cmd.op    = gfx_cmd_pkg::op_plot;
      cmd.x     = gfx_fb_pkg::fb_x_t'(5);
      cmd.y     = gfx_fb_pkg::fb_y_t'(5);
      cmd.color = ~color;
      @(posedge clk);
      #1;
      cycles++;
    end
    rd_en     = 1'b0;
    cmd_valid = 1'b0;
    if (busy) begin
      tb_errors++;
      $display("Clear did not finish within %0d cycles", cmd_timeout);
    end else if (cycles < gfx_fb_pkg::fb_pixels + reads) begin
      tb_errors++;
      $display("Error: %s: clear cycles expected at least %0d actual %0d",
               test_name, gfx_fb_pkg::fb_pixels + reads, cycles);
    end
    check_done_once(start_done);
  endtask

  // Back-to-back reads of the frame, rows past the bottom edge when asked
  task automatic read_frame(input bit beyond);
    int rows;
    rows = beyond ? (1 << gfx_fb_pkg::fb_y_bits) : gfx_fb_pkg::fb_height;
    for (int y = 0; y < rows; y++) begin
      for (int x = 0; x < gfx_fb_pkg::fb_width; x++) begin
        rd_en = 1'b1;
        rd_x  = gfx_fb_pkg::fb_x_t'(x);
        rd_y  = gfx_fb_pkg::fb_y_t'(y);
        @(posedge clk);
        #1;
      end
    end
    rd_en = 1'b0;
    repeat (2) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    #(clk_period * (n_tests * test_cycles + 5));
    $display("Timeout: the run did not finish within %0d cycles", n_tests * test_cycles + 5);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    void'($urandom(32'h7b58f1fc));
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    rd_en     = 1'b0;
    rd_x      = '0;
    rd_y      = '0;
    test_name = "reset";
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    begin_test("idle_after_reset");
    repeat (16) begin
      @(posedge clk);
      #1;
      if (busy || done || rd_valid) begin
        tb_errors++;
        $display("busy, done or rd_valid went high before any command");
      end
    end
    end_test();

    begin_test("clear");
    run_cmd(gfx_cmd_pkg::op_clear, '0, '0, gfx_fb_pkg::fb_color_t'($urandom));
    read_frame(1'b0);
    end_test();

    begin_test("plots");
    repeat (24) begin
      run_cmd(gfx_cmd_pkg::op_plot, gfx_fb_pkg::fb_x_t'($urandom),
              gfx_fb_pkg::fb_y_t'($urandom % gfx_fb_pkg::fb_height),
              gfx_fb_pkg::fb_color_t'($urandom));
    end
    read_frame(1'b0);
    end_test();

    begin_test("off_frame_plots");
    repeat (6) begin
      run_cmd(gfx_cmd_pkg::op_plot, gfx_fb_pkg::fb_x_t'($urandom),
              gfx_fb_pkg::fb_y_t'(gfx_fb_pkg::fb_height + $urandom % 4),
              gfx_fb_pkg::fb_color_t'($urandom));
    end
    read_frame(1'b1);
    end_test();

    begin_test("reads_during_clear");
    clear_with_traffic(gfx_fb_pkg::fb_color_t'($urandom), 30, 1'b0);
    read_frame(1'b0);
    end_test();

    begin_test("cmd_while_busy");
    clear_with_traffic(gfx_fb_pkg::fb_color_t'($urandom), 0, 1'b1);
    read_frame(1'b0);
    end_test();

    $display("Tests passed: %0d, failed: %0d, error count: %0d",
             tests_passed, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: build.f
gfx_fb_pkg.sv
gfx_cmd_pkg.sv
gfx_clear.sv
gfx_cmd_ctrl.sv
gfx_fb_writer.sv
gfx_top.sv
tb_gfx_asserts.sv
tb_gfx_checker.sv
tb_gfx.sv

// File: Bender.yml
package:
  name: gfx_fb

sources:
  - files:
      - gfx_fb_pkg.sv
      - gfx_cmd_pkg.sv
      - gfx_clear.sv
      - gfx_cmd_ctrl.sv
      - gfx_fb_writer.sv
      - gfx_top.sv
  - target: test
    files:
      - tb_gfx_asserts.sv
      - tb_gfx_checker.sv
      - tb_gfx.sv
